// ==== list.f ====
design/rv_isa_pkg.sv
design/csr_pkg.sv
design/ls_queue.sv
design/ls_ctrl.sv
design/lsu.sv
design/dmem_ram.sv
design/csr_file.sv
design/ls_stage.sv
verif/tb_ls_stage.sv

// ==== verif/tb_ls_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_ls_stage;
    import rv_isa_pkg::*;
    import csr_pkg::*;

    localparam int          QUEUE_DEPTH = 4;
    localparam logic [63:0] MTVEC_RESET = 64'h100;

    // op counts per section, sizing the watchdog
    localparam int N_INIT     = 16;
    localparam int N_ST       = 15;
    localparam int N_LD       = 116;
    localparam int N_BYP      = 9;
    localparam int N_CSR      = 16;
    localparam int N_TRAP     = 6;
    localparam int N_BURST    = 40;
    localparam int N_OPS      = N_INIT + N_ST + N_LD + N_BYP + N_CSR + N_TRAP + N_BURST;
    localparam int MAX_CYCLES = 2 * N_OPS + 200;

    logic                clk;
    logic                rst_i;
    logic                op_valid_i;
    logic [XLEN-1:0]     pc_i;
    logic [INST_LEN-1:0] instr_i;
    logic [XLEN-1:0]     alu_res_i;
    logic [XLEN-1:0]     rs2_i;
    logic                trap_i;
    logic                credit_o;
    logic                res_valid_o;
    logic [XLEN-1:0]     ls_res_o;
    logic [XLEN-1:0]     mtvec_o;
    logic [XLEN-1:0]     mepc_o;

    // reference model state
    logic [63:0] sh_mem [256];
    logic [63:0] sh_mtvec = MTVEC_RESET;
    logic [63:0] sh_mepc = '0;
    logic [63:0] sh_mcause = '0;
    logic [63:0] sh_mscratch = '0;
    logic        last_load = 1'b0;
    logic [4:0]  last_rd = '0;
    logic [63:0] last_res = '0;
    logic [63:0] pc_ctr = 64'h1000;

    // expected results in send order
    logic [63:0] exp_mem [512];
    logic [63:0] exp_head;
    int          exp_wr = 0;
    int          exp_rd = 0;

    int     credits = QUEUE_DEPTH;
    int     cycles = 0;
    int     mismatch_errs = 0;
    int     other_errs = 0;
    integer seed = 94;

    ls_stage u_ls_stage (
        .clk(clk), .rst_i(rst_i), .op_valid_i(op_valid_i), .pc_i(pc_i),
        .instr_i(instr_i), .alu_res_i(alu_res_i), .rs2_i(rs2_i), .trap_i(trap_i),
        .credit_o(credit_o), .res_valid_o(res_valid_o), .ls_res_o(ls_res_o),
        .mtvec_o(mtvec_o), .mepc_o(mepc_o)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    assign exp_head = exp_mem[exp_rd];

    // upstream credit count
    always @(posedge clk) begin
        if (rst_i) begin
            credits <= QUEUE_DEPTH;
        end else begin
            credits <= credits - int'(op_valid_i) + int'(credit_o);
        end
    end

    always @(posedge clk) begin
        if (!rst_i && res_valid_o && (exp_rd != exp_wr)) begin
            exp_rd <= exp_rd + 1;
        end
    end

    a_result_expected: assert property (@(posedge clk) disable iff (rst_i)
        res_valid_o |-> (exp_rd != exp_wr))
        else begin
            other_errs++;
            $display("result appeared at %0t with no operation pending", $time);
        end

    a_result_value: assert property (@(posedge clk) disable iff (rst_i)
        (res_valid_o && (exp_rd != exp_wr)) |-> (ls_res_o == exp_head))
        else begin
            mismatch_errs++;
            $display("mismatch at %0t: result %h, expected %h", $time,
                     $sampled(ls_res_o), $sampled(exp_head));
        end

    a_credit_bound: assert property (@(posedge clk) disable iff (rst_i)
        credits <= QUEUE_DEPTH)
        else begin
            other_errs++;
            $display("more credits returned than sent at %0t", $time);
        end

    // only when nothing is in flight does the shadow match the stage
    a_csr_outputs: assert property (@(posedge clk) disable iff (rst_i)
        ((credits == QUEUE_DEPTH) && !op_valid_i) |->
            ((mtvec_o == sh_mtvec) && (mepc_o == sh_mepc)))
        else begin
            mismatch_errs++;
            $display("mismatch at %0t: mtvec %h mepc %h, expected %h %h", $time,
                     $sampled(mtvec_o), $sampled(mepc_o), sh_mtvec, sh_mepc);
        end

    function automatic int nbytes(input logic [2:0] memop);
        return 1 << memop[1:0];
    endfunction

    function automatic logic [63:0] load_ref(input logic [2:0] memop, input logic [63:0] addr);
        logic [63:0] word;
        logic [63:0] res;
        int          n;
        word = sh_mem[addr[10:3]];
        n    = nbytes(memop);
        res  = '0;
        for (int i = 0; i < n; i++) begin
            res[8*i +: 8] = word[8*(addr[2:0] + i) +: 8];
        end
        // signed forms below 64 bits copy the top bit up
        if (!memop[2] && (n < 8) && res[8*n-1]) begin
            for (int i = n; i < 8; i++) begin
                res[8*i +: 8] = 8'hff;
            end
        end
        return res;
    endfunction

    task automatic store_ref(input logic [2:0] memop, input logic [63:0] addr,
                             input logic [63:0] data);
        int n;
        n = nbytes(memop);
        for (int i = 0; i < n; i++) begin
            sh_mem[addr[10:3]][8*(addr[2:0] + i) +: 8] = data[8*i +: 8];
        end
    endtask

    function automatic logic [11:0] csr_at(input int idx);
        case (idx)
            0:       return CSR_MTVEC;
            1:       return CSR_MEPC;
            2:       return CSR_MCAUSE;
            default: return CSR_MSCRATCH;
        endcase
    endfunction

    task automatic push_exp(input logic [63:0] val);
        exp_mem[exp_wr] = val;
        exp_wr          = exp_wr + 1;
    endtask

    task automatic wait_credit(input int n);
        while (credits < n) begin
            @(posedge clk);
            #1;
        end
    endtask

    // one op per call, valid for a single cycle
    task automatic drive_op(input logic [63:0] alu, input logic [31:0] instr,
                            input logic [63:0] rs2, input logic trap);
        op_valid_i = 1'b1;
        pc_i       = pc_ctr;
        instr_i    = instr;
        alu_res_i  = alu;
        rs2_i      = rs2;
        trap_i     = trap;
        pc_ctr     = pc_ctr + 64'd4;
        @(posedge clk);
        #1;
        op_valid_i = 1'b0;
        trap_i     = 1'b0;
    endtask

    task automatic load_op(input logic [2:0] memop, input logic [63:0] addr,
                           input logic [4:0] rd);
        logic [63:0] res;
        wait_credit(1);
        res = load_ref(memop, addr);
        push_exp(res);
        last_load = 1'b1;
        last_rd   = rd;
        last_res  = res;
        drive_op(addr, {12'd0, 5'd1, memop, rd, OPC_LOAD}, 64'd0, 1'b0);
    endtask

    task automatic store_op(input logic [2:0] memop, input logic [63:0] addr,
                            input logic [63:0] data, input logic [4:0] rs2f);
        logic [63:0] eff;
        wait_credit(1);
        // load result forwarded when rs2 names the previous load's rd
        eff = (last_load && (rs2f == last_rd)) ? last_res : data;
        store_ref(memop, addr, eff);
        last_load = 1'b0;
        drive_op(addr, {7'd0, rs2f, 5'd1, memop, 5'd0, OPC_STORE}, data, 1'b0);
    endtask

    task automatic csr_rmw(input logic [2:0] op, input logic [11:0] addr,
                           input logic [63:0] src);
        logic [63:0] old;
        logic [63:0] nxt;
        wait_credit(1);
        case (addr)
            CSR_MTVEC:    old = sh_mtvec;
            CSR_MEPC:     old = sh_mepc;
            CSR_MCAUSE:   old = sh_mcause;
            CSR_MSCRATCH: old = sh_mscratch;
            default:      old = '0;
        endcase
        case (op)
            CSR_RW:  nxt = src;
            CSR_RS:  nxt = old | src;
            default: nxt = old & ~src;
        endcase
        case (addr)
            CSR_MTVEC:    sh_mtvec = nxt;
            CSR_MEPC:     sh_mepc = nxt;
            CSR_MCAUSE:   sh_mcause = nxt;
            CSR_MSCRATCH: sh_mscratch = nxt;
            default:      ;
        endcase
        push_exp(old);
        last_load = 1'b0;
        drive_op(src, {addr, 5'd2, op, 5'd3, OPC_SYSTEM}, 64'd0, 1'b0);
    endtask

    // trapped op: mepc and mcause only, no result
    task automatic trap_op(input logic [31:0] instr, input logic [63:0] alu);
        wait_credit(1);
        sh_mepc   = pc_ctr;
        sh_mcause = CAUSE_TRAP;
        last_load = 1'b0;
        drive_op(alu, instr, 64'hffff_ffff_ffff_ffff, 1'b1);
    endtask

    task automatic idle_gap();
        if ($random(seed) & 1) begin
            @(posedge clk);
            #1;
        end
    endtask

    // all credits back, then a few cycles for the last results
    task automatic drain();
        while (credits != QUEUE_DEPTH) begin
            @(posedge clk);
            #1;
        end
        repeat (3) @(posedge clk);
        #1;
    endtask

    initial begin
        int          sel;
        int          wd;
        int          off;
        logic [2:0]  m;
        rst_i      = 1'b1;
        op_valid_i = 1'b0;
        pc_i       = '0;
        instr_i    = '0;
        alu_res_i  = '0;
        rs2_i      = '0;
        trap_i     = 1'b0;
        repeat (5) @(posedge clk);
        #1;
        rst_i = 1'b0;

        // fill words 0..15, no load reads unwritten bytes
        for (int w = 0; w < N_INIT; w++) begin
            store_op(MEMOP_SD, 64'(w * 8), {$random(seed), $random(seed)}, 5'd0);
            idle_gap();
        end
        // every store width at every aligned offset, width w in word w+1
        for (int w = 0; w < 4; w++) begin
            for (int o = 0; o < 8; o += (1 << w)) begin
                store_op(3'(w), 64'((w + 1) * 8 + o), {$random(seed), $random(seed)}, 5'd0);
                idle_gap();
            end
        end
        // lb lh lw ld lbu lhu lwu over words 1..4
        for (int k = 0; k < 7; k++) begin
            for (int o = 0; o < 8; o += (1 << k[1:0])) begin
                for (int w = 1; w < 5; w++) begin
                    load_op(3'(k), 64'(w * 8 + o), 5'd5);
                    idle_gap();
                end
            end
        end
        drain();

        // bypass pairs go back to back
        wait_credit(2);
        load_op(MEMOP_LD, 64'd16, 5'd7);
        store_op(MEMOP_SW, 64'd44, 64'h1111_2222_3333_4444, 5'd7);
        wait_credit(2);
        load_op(MEMOP_LH, 64'd26, 5'd7);
        store_op(MEMOP_SD, 64'd48, 64'h5555_6666_7777_8888, 5'd8);
        wait_credit(2);
        load_op(MEMOP_LB, 64'd9, 5'd9);
        store_op(MEMOP_SD, 64'd56, 64'd0, 5'd9);
        load_op(MEMOP_LD, 64'd40, 5'd5);
        load_op(MEMOP_LD, 64'd48, 5'd5);
        load_op(MEMOP_LD, 64'd56, 5'd5);
        drain();

        for (int c = 0; c < 4; c++) begin
            csr_rmw(CSR_RW, csr_at(c), {$random(seed), $random(seed)});
            csr_rmw(CSR_RS, csr_at(c), {$random(seed), $random(seed)});
            csr_rmw(CSR_RC, csr_at(c), {$random(seed), $random(seed)});
            csr_rmw(CSR_RS, csr_at(c), 64'd0);
        end
        drain();

        // trapped store, load and csr write, then read back
        trap_op({7'd0, 5'd0, 5'd1, MEMOP_SD, 5'd0, OPC_STORE}, 64'd8);
        trap_op({12'd0, 5'd1, MEMOP_LD, 5'd5, OPC_LOAD}, 64'd8);
        trap_op({CSR_MSCRATCH, 5'd2, CSR_RW, 5'd3, OPC_SYSTEM}, 64'hffff);
        csr_rmw(CSR_RS, CSR_MCAUSE, 64'd0);
        csr_rmw(CSR_RS, CSR_MSCRATCH, 64'd0);
        load_op(MEMOP_LD, 64'd8, 5'd5);
        drain();

        // burst as fast as credits allow, words 8..15
        for (int i = 0; i < N_BURST; i++) begin
            sel = $unsigned($random(seed)) % 4;
            wd  = 8 + ($unsigned($random(seed)) % 8);
            off = $unsigned($random(seed)) % 8;
            if (sel == 0) begin
                m   = 3'($unsigned($random(seed)) % 4);
                off = off & ~(nbytes(m) - 1);
                store_op(m, 64'(wd * 8 + off), {$random(seed), $random(seed)}, 5'd0);
            end else if (sel == 3) begin
                csr_rmw(CSR_RW, CSR_MSCRATCH, {$random(seed), $random(seed)});
            end else begin
                m   = 3'($unsigned($random(seed)) % 7);
                off = off & ~(nbytes(m) - 1);
                load_op(m, 64'(wd * 8 + off), 5'd5);
            end
        end
        drain();

        if (exp_rd != exp_wr) begin
            other_errs++;
            $display("missing result: %0d expected results never came back", exp_wr - exp_rd);
        end
        if (credits != QUEUE_DEPTH) begin
            other_errs++;
            $display("credits not all returned when idle: %0d of %0d", credits, QUEUE_DEPTH);
        end
        $display("checks done: %0d mismatches, %0d other errors", mismatch_errs, other_errs);
        if ((mismatch_errs + other_errs) == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    // watchdog
    initial begin
        while (cycles < MAX_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
        $display("checks done: %0d mismatches, %0d other errors", mismatch_errs, other_errs);
        $display("Regression failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== design/ls_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module ls_stage #(
    parameter int                          QUEUE_DEPTH = 4,
    parameter int                          MEM_WORDS   = 256,
    parameter logic [rv_isa_pkg::XLEN-1:0] MTVEC_RESET = 64'h100
) (
    input  wire                             clk,
    input  wire                             rst_i,
    input  wire                             op_valid_i,
    input  wire  [rv_isa_pkg::XLEN-1:0]     pc_i,
    input  wire  [rv_isa_pkg::INST_LEN-1:0] instr_i,
    input  wire  [rv_isa_pkg::XLEN-1:0]     alu_res_i,
    input  wire  [rv_isa_pkg::XLEN-1:0]     rs2_i,
    input  wire                             trap_i,
    output logic                            credit_o,
    output logic                            res_valid_o,
    output logic [rv_isa_pkg::XLEN-1:0]     ls_res_o,
    output logic [rv_isa_pkg::XLEN-1:0]     mtvec_o,
    output logic [rv_isa_pkg::XLEN-1:0]     mepc_o
);
    import rv_isa_pkg::*;

    // queue head
    logic                issue;
    logic [XLEN-1:0]     q_pc;
    logic [INST_LEN-1:0] q_instr;
    logic [XLEN-1:0]     q_alu;
    logic [XLEN-1:0]     q_rs2;
    logic                q_trap;
    // decode
    logic                rden;
    logic                wren;
    logic [2:0]          memop;
    logic [XLEN-1:0]     st_data;
    logic                csr_en;
    logic [2:0]          csr_op;
    logic [11:0]         csr_addr;
    logic                trap;
    // ram side
    logic [XLEN-4:0]     ram_addr;
    logic                ram_we;
    logic [7:0]          ram_be;
    logic [XLEN-1:0]     ram_wdata;
    logic                ram_re;
    logic [XLEN-1:0]     ram_rdata;
    // results
    logic [XLEN-1:0]     load_res;
    logic                load_valid;
    logic [XLEN-1:0]     csr_rdata;
    logic                csr_valid;

    ls_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_ls_queue (
        .clk(clk), .rst_i(rst_i), .push_i(op_valid_i),
        .pc_i(pc_i), .instr_i(instr_i), .alu_res_i(alu_res_i), .rs2_i(rs2_i),
        .trap_i(trap_i), .issue_o(issue), .pc_o(q_pc), .instr_o(q_instr),
        .alu_res_o(q_alu), .rs2_o(q_rs2), .trap_o(q_trap), .credit_o(credit_o)
    );

    ls_ctrl u_ls_ctrl (
        .clk(clk), .rst_i(rst_i), .issue_i(issue), .instr_i(q_instr),
        .trap_i(q_trap), .rs2_i(q_rs2), .load_res_i(load_res),
        .load_res_valid_i(load_valid), .rden_o(rden), .wren_o(wren),
        .memop_o(memop), .wr_data_o(st_data), .csr_en_o(csr_en),
        .csr_op_o(csr_op), .csr_addr_o(csr_addr), .trap_o(trap)
    );

    // alu result is the effective address
    lsu u_lsu (
        .clk(clk), .rst_i(rst_i), .rden_i(rden), .wren_i(wren), .memop_i(memop),
        .addr_i(q_alu), .wr_data_i(st_data), .ram_addr_o(ram_addr),
        .ram_we_o(ram_we), .ram_be_o(ram_be), .ram_wdata_o(ram_wdata),
        .ram_re_o(ram_re), .ram_rdata_i(ram_rdata), .load_res_o(load_res),
        .load_valid_o(load_valid)
    );

    dmem_ram #(.MEM_WORDS(MEM_WORDS)) u_dmem_ram (
        .clk(clk), .addr_i(ram_addr), .we_i(ram_we), .be_i(ram_be),
        .wdata_i(ram_wdata), .re_i(ram_re), .rdata_o(ram_rdata)
    );

    // alu result doubles as csr source
    csr_file #(.MTVEC_RESET(MTVEC_RESET)) u_csr_file (
        .clk(clk), .rst_i(rst_i), .csr_en_i(csr_en), .csr_op_i(csr_op),
        .csr_addr_i(csr_addr), .csr_wdata_i(q_alu), .trap_i(trap), .pc_i(q_pc),
        .csr_rdata_o(csr_rdata), .csr_valid_o(csr_valid), .mtvec_o(mtvec_o),
        .mepc_o(mepc_o)
    );

    // both sources are zero when idle, one op yields one of them
    assign res_valid_o = load_valid | csr_valid;
    assign ls_res_o    = load_res | csr_rdata;

endmodule

`default_nettype wire

// ==== design/csr_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module csr_file #(
    parameter logic [rv_isa_pkg::XLEN-1:0] MTVEC_RESET = 64'h100
) (
    input  wire                         clk,
    input  wire                         rst_i,
    input  wire                         csr_en_i,
    input  wire  [2:0]                  csr_op_i,
    input  wire  [11:0]                 csr_addr_i,
    input  wire  [rv_isa_pkg::XLEN-1:0] csr_wdata_i,
    input  wire                         trap_i,
    input  wire  [rv_isa_pkg::XLEN-1:0] pc_i,
    output logic [rv_isa_pkg::XLEN-1:0] csr_rdata_o,
    output logic                        csr_valid_o,
    output logic [rv_isa_pkg::XLEN-1:0] mtvec_o,
    output logic [rv_isa_pkg::XLEN-1:0] mepc_o
);
    import rv_isa_pkg::*;
    import csr_pkg::*;

    logic [XLEN-1:0] mtvec_q;
    logic [XLEN-1:0] mepc_q;
    logic [XLEN-1:0] mcause_q;
    logic [XLEN-1:0] mscratch_q;
    logic [XLEN-1:0] old_val;
    logic [XLEN-1:0] new_val;
    logic [XLEN-1:0] rdata_q;
    logic            valid_q;

    // unknown address reads zero
    always_comb begin
        case (csr_addr_i)
            CSR_MTVEC:    old_val = mtvec_q;
            CSR_MEPC:     old_val = mepc_q;
            CSR_MCAUSE:   old_val = mcause_q;
            CSR_MSCRATCH: old_val = mscratch_q;
            default:      old_val = '0;
        endcase
    end

    always_comb begin
        case (csr_op_i)
            CSR_RW:  new_val = csr_wdata_i;
            CSR_RS:  new_val = old_val | csr_wdata_i;
            CSR_RC:  new_val = old_val & ~csr_wdata_i;
            default: new_val = old_val;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            mtvec_q    <= MTVEC_RESET;
            mepc_q     <= '0;
            mcause_q   <= '0;
            mscratch_q <= '0;
            valid_q    <= 1'b0;
        end else begin
            valid_q <= csr_en_i;
            if (trap_i) begin
                // trap capture
                mepc_q   <= pc_i;
                mcause_q <= CAUSE_TRAP;
            end else if (csr_en_i) begin
                case (csr_addr_i)
                    CSR_MTVEC:    mtvec_q    <= new_val;
                    CSR_MEPC:     mepc_q     <= new_val;
                    CSR_MCAUSE:   mcause_q   <= new_val;
                    CSR_MSCRATCH: mscratch_q <= new_val;
                    default:      ;
                endcase
            end
        end
    end

    // old value goes back to writeback next cycle
    always_ff @(posedge clk) begin
        if (csr_en_i) begin
            rdata_q <= old_val;
        end
    end

    assign csr_rdata_o = valid_q ? rdata_q : '0;
    assign csr_valid_o = valid_q;
    assign mtvec_o     = mtvec_q;
    assign mepc_o      = mepc_q;

    // decode suppresses the csr access of a trapping op
    a_csr_vs_trap: assert property (@(posedge clk) disable iff (rst_i)
        !(csr_en_i && trap_i));

endmodule

`default_nettype wire

// ==== design/dmem_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module dmem_ram #(
    parameter int MEM_WORDS = 256
) (
    input  wire                         clk,
    input  wire  [rv_isa_pkg::XLEN-4:0] addr_i,
    input  wire                         we_i,
    input  wire  [7:0]                  be_i,
    input  wire  [rv_isa_pkg::XLEN-1:0] wdata_i,
    input  wire                         re_i,
    output logic [rv_isa_pkg::XLEN-1:0] rdata_o
);
    import rv_isa_pkg::*;

    localparam int AW = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

    logic [XLEN-1:0] mem [MEM_WORDS];
    logic [AW-1:0]   idx;

    assign idx = addr_i[AW-1:0];

    // byte-lane writes, read data one cycle later
    always_ff @(posedge clk) begin
        if (we_i) begin
            for (int b = 0; b < XLEN / 8; b++) begin
                if (be_i[b]) begin
                    mem[idx][8*b +: 8] <= wdata_i[8*b +: 8];
                end
            end
        end
        if (re_i) begin
            rdata_o <= mem[idx];
        end
    end

    // no wraparound of out-of-range word addresses
    a_addr_range: assert property (@(posedge clk)
        (we_i || re_i) |-> (addr_i < MEM_WORDS));

endmodule

`default_nettype wire

// ==== design/lsu.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu (
    input  wire                         clk,
    input  wire                         rst_i,
    input  wire                         rden_i,
    input  wire                         wren_i,
    input  wire  [2:0]                  memop_i,
    input  wire  [rv_isa_pkg::XLEN-1:0] addr_i,
    input  wire  [rv_isa_pkg::XLEN-1:0] wr_data_i,
    output logic [rv_isa_pkg::XLEN-4:0] ram_addr_o,
    output logic                        ram_we_o,
    output logic [7:0]                  ram_be_o,
    output logic [rv_isa_pkg::XLEN-1:0] ram_wdata_o,
    output logic                        ram_re_o,
    input  wire  [rv_isa_pkg::XLEN-1:0] ram_rdata_i,
    output logic [rv_isa_pkg::XLEN-1:0] load_res_o,
    output logic                        load_valid_o
);
    import rv_isa_pkg::*;

    logic [2:0]      off;
    logic [2:0]      align_mask;
    logic [7:0]      be_base;
    logic            ld_valid_q;
    logic [2:0]      ld_memop_q;
    logic [2:0]      ld_off_q;
    logic [XLEN-1:0] ld_shift;
    logic [XLEN-1:0] ld_ext;

    // byte offset inside the 64-bit word
    assign off        = addr_i[2:0];
    assign ram_addr_o = addr_i[XLEN-1:3];
    assign ram_we_o   = wren_i;
    assign ram_re_o   = rden_i;

    // size from funct3[1:0], offset bits that must be zero
    assign align_mask = {memop_i[1:0] == 2'b11, memop_i[1], |memop_i[1:0]};
    // 1, 2, 4 or 8 lanes
    assign be_base    = {{4{align_mask[2]}}, {2{align_mask[1]}}, align_mask[0], 1'b1};

    assign ram_be_o    = wren_i ? (be_base << off) : 8'h00;
    assign ram_wdata_o = wr_data_i << {off, 3'b000};

    always_ff @(posedge clk) begin
        if (rst_i) begin
            ld_valid_q <= 1'b0;
        end else begin
            ld_valid_q <= rden_i;
        end
    end

    // kept for the extract when the ram word comes back
    always_ff @(posedge clk) begin
        if (rden_i) begin
            ld_memop_q <= memop_i;
            ld_off_q   <= off;
        end
    end

    // field down to bit 0
    assign ld_shift = ram_rdata_i >> {ld_off_q, 3'b000};

    always_comb begin
        case (ld_memop_q)
            MEMOP_LB:  ld_ext = {{(XLEN-8){ld_shift[7]}}, ld_shift[7:0]};
            MEMOP_LH:  ld_ext = {{(XLEN-16){ld_shift[15]}}, ld_shift[15:0]};
            MEMOP_LW:  ld_ext = {{(XLEN-32){ld_shift[31]}}, ld_shift[31:0]};
            MEMOP_LBU: ld_ext = {{(XLEN-8){1'b0}}, ld_shift[7:0]};
            MEMOP_LHU: ld_ext = {{(XLEN-16){1'b0}}, ld_shift[15:0]};
            MEMOP_LWU: ld_ext = {{(XLEN-32){1'b0}}, ld_shift[31:0]};
            // ld
            default:   ld_ext = ld_shift;
        endcase
    end

    // zero when idle so the top can OR with csr data
    assign load_res_o   = ld_valid_q ? ld_ext : '0;
    assign load_valid_o = ld_valid_q;

    // misaligned accesses not supported
    a_aligned: assert property (@(posedge clk) disable iff (rst_i)
        (rden_i | wren_i) |-> ((off & align_mask) == 3'b000));

endmodule

`default_nettype wire

// ==== design/ls_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module ls_ctrl (
    input  wire                         clk,
    input  wire                         rst_i,
    input  wire                         issue_i,
    input  wire  rv_isa_pkg::instr_u    instr_i,
    input  wire                         trap_i,
    input  wire  [rv_isa_pkg::XLEN-1:0] rs2_i,
    input  wire  [rv_isa_pkg::XLEN-1:0] load_res_i,
    input  wire                         load_res_valid_i,
    output logic                        rden_o,
    output logic                        wren_o,
    output logic [2:0]                  memop_o,
    output logic [rv_isa_pkg::XLEN-1:0] wr_data_o,
    output logic                        csr_en_o,
    output logic [2:0]                  csr_op_o,
    output logic [11:0]                 csr_addr_o,
    output logic                        trap_o
);
    import rv_isa_pkg::*;
    import csr_pkg::*;

    logic       go;
    logic       is_load;
    logic       is_store;
    logic       is_csr;
    logic       prev_load_q;
    logic [4:0] load_rd_q;
    logic       bypass;

    // a trapping op does nothing but the trap
    assign go = issue_i & ~trap_i;

    assign is_load  = (instr_i.i_fmt.opcode == OPC_LOAD);
    assign is_store = (instr_i.s_fmt.opcode == OPC_STORE);
    assign is_csr   = (instr_i.i_fmt.opcode == OPC_SYSTEM) &&
                      (instr_i.i_fmt.funct3 inside {CSR_RW, CSR_RS, CSR_RC});

    assign rden_o     = go & is_load;
    assign wren_o     = go & is_store;
    assign csr_en_o   = go & is_csr;
    assign trap_o     = issue_i & trap_i;
    assign memop_o    = instr_i.i_fmt.funct3;
    assign csr_op_o   = instr_i.i_fmt.funct3;
    assign csr_addr_o = instr_i.i_fmt.imm;

    // store right behind a load that produces its rs2
    assign bypass    = prev_load_q & load_res_valid_i & (instr_i.s_fmt.rs2 == load_rd_q);
    assign wr_data_o = bypass ? load_res_i : rs2_i;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            prev_load_q <= 1'b0;
        end else begin
            prev_load_q <= rden_o;
        end
    end

    always_ff @(posedge clk) begin
        if (rden_o) begin
            load_rd_q <= instr_i.i_fmt.rd;
        end
    end

endmodule

`default_nettype wire

// ==== design/ls_queue.sv ====
`timescale 1ns/1ps
`default_nettype none

module ls_queue #(
    parameter int QUEUE_DEPTH = 4
) (
    input  wire                              clk,
    input  wire                              rst_i,
    input  wire                              push_i,
    input  wire  [rv_isa_pkg::XLEN-1:0]      pc_i,
    input  wire  [rv_isa_pkg::INST_LEN-1:0]  instr_i,
    input  wire  [rv_isa_pkg::XLEN-1:0]      alu_res_i,
    input  wire  [rv_isa_pkg::XLEN-1:0]      rs2_i,
    input  wire                              trap_i,
    output logic                             issue_o,
    output logic [rv_isa_pkg::XLEN-1:0]      pc_o,
    output logic [rv_isa_pkg::INST_LEN-1:0]  instr_o,
    output logic [rv_isa_pkg::XLEN-1:0]      alu_res_o,
    output logic [rv_isa_pkg::XLEN-1:0]      rs2_o,
    output logic                             trap_o,
    output logic                             credit_o
);
    import rv_isa_pkg::*;

    localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    // one slot per credit
    logic [XLEN-1:0]     pc_q    [QUEUE_DEPTH];
    logic [INST_LEN-1:0] instr_q [QUEUE_DEPTH];
    logic [XLEN-1:0]     alu_q   [QUEUE_DEPTH];
    logic [XLEN-1:0]     rs2_q   [QUEUE_DEPTH];
    logic                trap_q  [QUEUE_DEPTH];
    logic [PTR_W-1:0]    wr_ptr;
    logic [PTR_W-1:0]    rd_ptr;
    logic [CNT_W-1:0]    count;

    // head leaves every cycle it is present
    assign issue_o   = (count != '0);
    assign pc_o      = pc_q[rd_ptr];
    assign instr_o   = instr_q[rd_ptr];
    assign alu_res_o = alu_q[rd_ptr];
    assign rs2_o     = rs2_q[rd_ptr];
    assign trap_o    = trap_q[rd_ptr];

    always_ff @(posedge clk) begin
        if (push_i) begin
            pc_q[wr_ptr]    <= pc_i;
            instr_q[wr_ptr] <= instr_i;
            alu_q[wr_ptr]   <= alu_res_i;
            rs2_q[wr_ptr]   <= rs2_i;
            trap_q[wr_ptr]  <= trap_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            credit_o <= 1'b0;
        end else begin
            if (push_i) begin
                wr_ptr <= (wr_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + PTR_W'(1);
            end
            if (issue_o) begin
                rd_ptr <= (rd_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + PTR_W'(1);
            end
            count    <= count + CNT_W'(push_i) - CNT_W'(issue_o);
            // one credit back per pop
            credit_o <= issue_o;
        end
    end

    // upstream pushes only while holding a credit
    a_push_not_full: assert property (@(posedge clk) disable iff (rst_i)
        push_i |-> (count < CNT_W'(QUEUE_DEPTH)));

    a_count_bound: assert property (@(posedge clk) disable iff (rst_i)
        count <= CNT_W'(QUEUE_DEPTH));

endmodule

`default_nettype wire

// ==== design/csr_pkg.sv ====
`default_nettype none

package csr_pkg;

    // machine csr addresses
    localparam logic [11:0] CSR_MTVEC    = 12'h305;
    localparam logic [11:0] CSR_MSCRATCH = 12'h340;
    localparam logic [11:0] CSR_MEPC     = 12'h341;
    localparam logic [11:0] CSR_MCAUSE   = 12'h342;

    // register forms only
    localparam logic [2:0] CSR_RW = 3'b001;
    localparam logic [2:0] CSR_RS = 3'b010;
    localparam logic [2:0] CSR_RC = 3'b011;

    // illegal instruction cause
    localparam logic [63:0] CAUSE_TRAP = 64'd2;

endpackage

`default_nettype wire

// ==== design/rv_isa_pkg.sv ====
`default_nettype none

package rv_isa_pkg;

    // datapath width, the load extraction is written for 64 bits
    localparam int XLEN     = 64;
    localparam int INST_LEN = 32;

    // major opcodes
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    // load funct3
    localparam logic [2:0] MEMOP_LB  = 3'b000;
    localparam logic [2:0] MEMOP_LH  = 3'b001;
    localparam logic [2:0] MEMOP_LW  = 3'b010;
    localparam logic [2:0] MEMOP_LD  = 3'b011;
    localparam logic [2:0] MEMOP_LBU = 3'b100;
    localparam logic [2:0] MEMOP_LHU = 3'b101;
    localparam logic [2:0] MEMOP_LWU = 3'b110;

    // store funct3, same encodings as the signed loads
    localparam logic [2:0] MEMOP_SB = 3'b000;
    localparam logic [2:0] MEMOP_SH = 3'b001;
    localparam logic [2:0] MEMOP_SW = 3'b010;
    localparam logic [2:0] MEMOP_SD = 3'b011;

    // one instruction word, two decodings
    typedef union packed {
        struct packed {
            logic [6:0] imm_hi;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] imm_lo;
            logic [6:0] opcode;
        } s_fmt;
        struct packed {
            // csr address for SYSTEM
            logic [11:0] imm;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i_fmt;
    } instr_u;

endpackage

`default_nettype wire
